// File: src/msu_pkg.sv
package msu_pkg;

  ////////////////////
  // Widths
  ////////////////////
  typedef logic [7:0]  byte_t;
  typedef logic [13:0] buf_addr_t;
  typedef logic [2:0]  reg_sel_t;
  typedef logic [31:0] seek_addr_t;
  typedef logic [15:0] track_t;
  typedef logic [5:0]  status_bits_t;
  typedef logic [6:0]  status_out_t;

  localparam int BUF_DEPTH = 16384;

  // Write side of the register map, seek bytes lowest first
  localparam reg_sel_t WR_SEEK0  = 3'd0;
  localparam reg_sel_t WR_SEEK1  = 3'd1;
  localparam reg_sel_t WR_SEEK2  = 3'd2;
  localparam reg_sel_t WR_SEEK3  = 3'd3;
  localparam reg_sel_t WR_TRACK0 = 3'd4;
  localparam reg_sel_t WR_TRACK1 = 3'd5;
  localparam reg_sel_t WR_VOLUME = 3'd6;
  localparam reg_sel_t WR_CTRL   = 3'd7;

  // Read side decodes the same address differently
  localparam reg_sel_t RD_STATUS   = 3'd0;
  localparam reg_sel_t RD_DATA     = 3'd1;
  localparam reg_sel_t RD_ID_FIRST = 3'd2;

  // "S-MSU1"
  localparam byte_t MSU_ID [6] = '{8'h53, 8'h2d, 8'h4d, 8'h53, 8'h55, 8'h31};

  ////////////////////
  // Status
  ////////////////////
  localparam logic [2:0] STATUS_LOW = 3'b001;

  // Bit positions in the set and clear masks
  localparam int ST_AUDIO_BUSY   = 5;
  localparam int ST_DATA_BUSY    = 4;
  localparam int ST_AUDIO_ERROR  = 3;
  localparam int ST_AUDIO_STATUS = 1;
  localparam int ST_CTRL_ACK     = 0;

endpackage

// File: src/msu_bus_if.sv
`timescale 1ns/1ps

interface msu_bus_if;
  import msu_pkg::*;

  // Host access, already edge detected and aligned to the pulses
  logic     enable;
  reg_sel_t addr;
  byte_t    wdata;
  logic     rd_start;
  logic     rd_end;
  logic     wr_end;

  modport src (
    output enable, addr, wdata,
    output rd_start, rd_end, wr_end
  );

  modport dst (
    input enable, addr, wdata,
    input rd_start, rd_end, wr_end
  );

endinterface

// File: src/msu_strobe_sync.sv
`timescale 1ns/1ps

module msu_strobe_sync (
  input  logic               clkin,
  input  logic               rst_n,
  input  logic               enable,
  input  msu_pkg::reg_sel_t  reg_addr,
  input  msu_pkg::byte_t     reg_data_in,
  input  logic               reg_rd_n,
  input  logic               reg_wr_n,
  input  logic               status_reset_we,
  input  msu_pkg::buf_addr_t msu_address_ext,
  input  logic               msu_address_ext_write,
  msu_bus_if.src             bus,
  output logic               status_upd,
  output logic               ext_load,
  output msu_pkg::buf_addr_t ext_addr
);
  import msu_pkg::*;

  logic       rd_q;
  logic       rd_prev;
  logic       wr_q;
  logic       wr_prev;
  logic       en_q;
  reg_sel_t   addr_q;
  byte_t      wdata_q;
  logic [1:0] st_sr;
  logic [1:0] ext_sr;

  ////////////////////
  // Host strobes
  ////////////////////
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      rd_q         <= 1'b1;
      rd_prev      <= 1'b1;
      wr_q         <= 1'b1;
      wr_prev      <= 1'b1;
      en_q         <= 1'b0;
      bus.enable   <= 1'b0;
      bus.rd_start <= 1'b0;
      bus.rd_end   <= 1'b0;
      bus.wr_end   <= 1'b0;
    end else begin
      rd_q         <= reg_rd_n;
      rd_prev      <= rd_q;
      wr_q         <= reg_wr_n;
      wr_prev      <= wr_q;
      en_q         <= enable;
      bus.enable   <= en_q;
      // Strobes are active low
      bus.rd_start <= rd_prev & ~rd_q;
      bus.rd_end   <= ~rd_prev & rd_q;
      bus.wr_end   <= ~wr_prev & wr_q;
    end
  end

  // Address and data follow the same two stages as the strobes
  always_ff @(posedge clkin) begin
    addr_q    <= reg_addr;
    wdata_q   <= reg_data_in;
    bus.addr  <= addr_q;
    bus.wdata <= wdata_q;
  end

  ////////////////////
  // Controller strobes
  ////////////////////
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      st_sr    <= 2'b00;
      ext_sr   <= 2'b00;
      ext_load <= 1'b0;
    end else begin
      st_sr    <= {st_sr[0], status_reset_we};
      ext_sr   <= {ext_sr[0], msu_address_ext_write};
      ext_load <= ext_sr[0] & ~ext_sr[1];
    end
  end

  assign status_upd = st_sr[0] & ~st_sr[1];

  // Pointer value captured with the load pulse
  always_ff @(posedge clkin) begin
    if (ext_sr[0] && !ext_sr[1]) begin
      ext_addr <= msu_address_ext;
    end
  end

endmodule

// File: src/msu_databuf.sv
`timescale 1ns/1ps

module msu_databuf (
  input  logic               clkin,
  input  logic               wr_en,
  input  msu_pkg::buf_addr_t wr_addr,
  input  msu_pkg::byte_t     wr_data,
  input  msu_pkg::buf_addr_t rd_addr,
  output msu_pkg::byte_t     rd_data
);
  import msu_pkg::*;

  byte_t mem [BUF_DEPTH];

  // Program port from the side controller
  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Host side read, one clock of latency
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: src/msu_regs.sv
`timescale 1ns/1ps

module msu_regs (
  input  logic                  clkin,
  input  logic                  rst_n,
  msu_bus_if.dst                bus,
  input  logic                  status_upd,
  input  logic                  ext_load,
  input  msu_pkg::buf_addr_t    ext_addr,
  input  msu_pkg::status_bits_t status_set_bits,
  input  msu_pkg::status_bits_t status_reset_bits,
  output msu_pkg::buf_addr_t    buf_rd_addr,
  input  msu_pkg::byte_t        buf_rd_data,
  output msu_pkg::byte_t        reg_data_out,
  output msu_pkg::status_out_t  status_out,
  output msu_pkg::byte_t        volume_out,
  output logic                  volume_latch_out,
  output msu_pkg::seek_addr_t   addr_out,
  output msu_pkg::track_t       track_out
);
  import msu_pkg::*;

  buf_addr_t  ptr;
  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       audio_error;
  logic [1:0] audio_status;
  logic [2:0] audio_ctrl;
  logic       ctrl_ack;
  logic       host_rd;
  logic       host_wr;
  logic       data_rd_done;
  byte_t      status_byte;
  reg_sel_t   id_idx;

  assign host_rd      = bus.rd_start & bus.enable;
  assign host_wr      = bus.wr_end & bus.enable;
  assign data_rd_done = bus.rd_end & bus.enable & (bus.addr == RD_DATA);

  assign status_byte = {data_busy, audio_busy, audio_status, audio_error, STATUS_LOW};
  assign id_idx      = bus.addr - RD_ID_FIRST;

  ////////////////////
  // Buffer pointer
  ////////////////////
  // Controller load wins over the host increment
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (ext_load) begin
      ptr <= ext_addr;
    end else if (data_rd_done) begin
      ptr <= ptr + 14'd1;
    end
  end

  assign buf_rd_addr = ptr;

  ////////////////////
  // Read path
  ////////////////////
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      reg_data_out <= '0;
    end else if (host_rd) begin
      case (bus.addr)
        RD_STATUS: reg_data_out <= status_byte;
        RD_DATA:   reg_data_out <= buf_rd_data;
        default:   reg_data_out <= MSU_ID[id_idx];
      endcase
    end
  end

  ////////////////////
  // Write path and flags
  ////////////////////
  always_ff @(posedge clkin or negedge rst_n) begin
    if (!rst_n) begin
      addr_out         <= '0;
      track_out        <= '0;
      volume_out       <= '0;
      volume_latch_out <= 1'b0;
      audio_start      <= 1'b0;
      audio_busy       <= 1'b1;
      data_start       <= 1'b0;
      data_busy        <= 1'b1;
      audio_error      <= 1'b0;
      audio_status     <= 2'b00;
      audio_ctrl       <= 3'b000;
      ctrl_ack         <= 1'b0;
    end else begin
      // Latch pulse lasts a single cycle
      volume_latch_out <= 1'b0;
      if (host_wr) begin
        case (bus.addr)
          WR_SEEK0: addr_out[7:0]   <= bus.wdata;
          WR_SEEK1: addr_out[15:8]  <= bus.wdata;
          WR_SEEK2: addr_out[23:16] <= bus.wdata;
          WR_SEEK3: begin
            addr_out[31:24] <= bus.wdata;
            data_start      <= 1'b1;
            data_busy       <= 1'b1;
          end
          WR_TRACK0: track_out[7:0] <= bus.wdata;
          WR_TRACK1: begin
            track_out[15:8] <= bus.wdata;
            audio_start     <= 1'b1;
            audio_busy      <= 1'b1;
          end
          WR_VOLUME: begin
            volume_out       <= bus.wdata;
            volume_latch_out <= 1'b1;
          end
          WR_CTRL: begin
            // Ignored while a track is still being prepared
            if (!audio_busy) begin
              audio_ctrl <= bus.wdata[2:0];
              ctrl_ack   <= 1'b1;
            end
          end
          default: ;
        endcase
      end else if (status_upd) begin
        // Set first, then clear
        audio_busy <= (audio_busy | status_set_bits[ST_AUDIO_BUSY])
                      & ~status_reset_bits[ST_AUDIO_BUSY];
        data_busy <= (data_busy | status_set_bits[ST_DATA_BUSY])
                     & ~status_reset_bits[ST_DATA_BUSY];
        audio_error <= (audio_error | status_set_bits[ST_AUDIO_ERROR])
                       & ~status_reset_bits[ST_AUDIO_ERROR];
        audio_status <= (audio_status | status_set_bits[ST_AUDIO_STATUS +: 2])
                        & ~status_reset_bits[ST_AUDIO_STATUS +: 2];
        ctrl_ack <= (ctrl_ack | status_set_bits[ST_CTRL_ACK])
                    & ~status_reset_bits[ST_CTRL_ACK];
        // Clearing busy also retires the start request
        if (status_reset_bits[ST_AUDIO_BUSY]) begin
          audio_start <= 1'b0;
        end
        if (status_reset_bits[ST_DATA_BUSY]) begin
          data_start <= 1'b0;
        end
      end
    end
  end

  // Control field sits above the acknowledge in bits 3:1
  assign status_out = {ptr[13], audio_start, data_start, audio_ctrl, ctrl_ack};

endmodule

// File: src/msu_top.sv
`timescale 1ns/1ps

module msu_top (
  input  logic                  clkin,
  input  logic                  rst_n,
  input  logic                  enable,
  // Program port from the side controller
  input  msu_pkg::buf_addr_t    pgm_address,
  input  msu_pkg::byte_t        pgm_data,
  input  logic                  pgm_we_n,
  // Host register window
  input  msu_pkg::reg_sel_t     reg_addr,
  input  msu_pkg::byte_t        reg_data_in,
  input  logic                  reg_rd_n,
  input  logic                  reg_wr_n,
  output msu_pkg::byte_t        reg_data_out,
  // Controller status and pointer
  input  logic                  status_reset_we,
  input  msu_pkg::status_bits_t status_set_bits,
  input  msu_pkg::status_bits_t status_reset_bits,
  input  msu_pkg::buf_addr_t    msu_address_ext,
  input  logic                  msu_address_ext_write,
  output msu_pkg::status_out_t  status_out,
  output msu_pkg::byte_t        volume_out,
  output logic                  volume_latch_out,
  output msu_pkg::seek_addr_t   addr_out,
  output msu_pkg::track_t       track_out
);
  import msu_pkg::*;

  logic      status_upd;
  logic      ext_load;
  buf_addr_t ext_addr;
  buf_addr_t buf_rd_addr;
  byte_t     buf_rd_data;

  msu_bus_if u_bus ();

  msu_strobe_sync u_strobe_sync (
    .clkin                 (clkin),
    .rst_n                 (rst_n),
    .enable                (enable),
    .reg_addr              (reg_addr),
    .reg_data_in           (reg_data_in),
    .reg_rd_n              (reg_rd_n),
    .reg_wr_n              (reg_wr_n),
    .status_reset_we       (status_reset_we),
    .msu_address_ext       (msu_address_ext),
    .msu_address_ext_write (msu_address_ext_write),
    .bus                   (u_bus.src),
    .status_upd            (status_upd),
    .ext_load              (ext_load),
    .ext_addr              (ext_addr)
  );

  msu_databuf u_databuf (
    .clkin   (clkin),
    .wr_en   (~pgm_we_n),
    .wr_addr (pgm_address),
    .wr_data (pgm_data),
    .rd_addr (buf_rd_addr),
    .rd_data (buf_rd_data)
  );

  msu_regs u_regs (
    .clkin             (clkin),
    .rst_n             (rst_n),
    .bus               (u_bus.dst),
    .status_upd        (status_upd),
    .ext_load          (ext_load),
    .ext_addr          (ext_addr),
    .status_set_bits   (status_set_bits),
    .status_reset_bits (status_reset_bits),
    .buf_rd_addr       (buf_rd_addr),
    .buf_rd_data       (buf_rd_data),
    .reg_data_out      (reg_data_out),
    .status_out        (status_out),
    .volume_out        (volume_out),
    .volume_latch_out  (volume_latch_out),
    .addr_out          (addr_out),
    .track_out         (track_out)
  );

endmodule

// File: dv/msu_props.sv
`timescale 1ns/1ps

module msu_props (
  input logic               clkin,
  input logic               rst_n,
  input logic               volume_latch_out,
  input logic               bus_en,
  input logic               wr_end,
  input logic               rd_end,
  input logic               ext_load,
  input msu_pkg::reg_sel_t  sel,
  input logic               audio_busy,
  input logic [2:0]         audio_ctrl,
  input msu_pkg::buf_addr_t ptr
);
  import msu_pkg::*;

  // Latch is a single-cycle pulse
  a_latch_single: assert property (@(posedge clkin) disable iff (!rst_n)
    volume_latch_out |=> !volume_latch_out)
    else $error("volume latch high on two consecutive cycles");

  // Control field frozen while a track is being prepared
  a_ctrl_busy: assert property (@(posedge clkin) disable iff (!rst_n)
    bus_en && wr_end && (sel == WR_CTRL) && audio_busy |=> $stable(audio_ctrl))
    else $error("control field changed while audio busy");

  a_ptr_incr: assert property (@(posedge clkin) disable iff (!rst_n)
    bus_en && rd_end && (sel == RD_DATA) && !ext_load |=> ptr == $past(ptr) + 14'd1)
    else $error("buffer pointer did not advance after a data read");

endmodule

bind msu_regs msu_props u_props (
  .clkin            (clkin),
  .rst_n            (rst_n),
  .volume_latch_out (volume_latch_out),
  .bus_en           (bus.enable),
  .wr_end           (bus.wr_end),
  .rd_end           (bus.rd_end),
  .ext_load         (ext_load),
  .sel              (bus.addr),
  .audio_busy       (audio_busy),
  .audio_ctrl       (audio_ctrl),
  .ptr              (ptr)
);

// File: dv/msu_tb.sv
`timescale 1ns/1ps

module msu_tb;
  import msu_pkg::*;

  localparam int N_OPS      = 200;
  localparam int MAX_CYCLES = N_OPS * 16 + 500;
  localparam byte_t ID_BYTES [6] = '{"S", "-", "M", "S", "U", "1"};

  logic         clkin;
  logic         rst_n;
  logic         enable;
  buf_addr_t    pgm_address;
  byte_t        pgm_data;
  logic         pgm_we_n;
  reg_sel_t     reg_addr;
  byte_t        reg_data_in;
  logic         reg_rd_n;
  logic         reg_wr_n;
  byte_t        reg_data_out;
  logic         status_reset_we;
  status_bits_t status_set_bits;
  status_bits_t status_reset_bits;
  buf_addr_t    msu_address_ext;
  logic         msu_address_ext_write;
  status_out_t  status_out;
  byte_t        volume_out;
  logic         volume_latch_out;
  seek_addr_t   addr_out;
  track_t       track_out;

  // Reference model state
  byte_t      m_buf [BUF_DEPTH];
  bit         m_written [BUF_DEPTH];
  buf_addr_t  m_ptr;
  seek_addr_t m_seek;
  track_t     m_track;
  byte_t      m_vol;
  byte_t      m_rdata;
  logic       m_astart;
  logic       m_abusy;
  logic       m_dstart;
  logic       m_dbusy;
  logic       m_aerr;
  logic [1:0] m_astat;
  logic [2:0] m_ctrl;
  logic       m_ack;

  int err_byte;
  int err_seek;
  int err_track;
  int err_status;
  int latch_cnt;
  int cycles;
  int op;

  msu_top u_msu_top (.*);

  initial begin
    clkin = 1'b0;
    forever #4 clkin = ~clkin;
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clkin);
      cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////
  // Compare tasks
  ////////////////////
  task automatic check_byte(input string what, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      err_byte++;
      $display("MISMATCH at %0t: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_seek(input seek_addr_t got, input seek_addr_t exp);
    if (got !== exp) begin
      err_seek++;
      $display("MISMATCH at %0t: addr_out is %08h, expected %08h", $time, got, exp);
    end
  endtask

  task automatic check_track(input track_t got, input track_t exp);
    if (got !== exp) begin
      err_track++;
      $display("MISMATCH at %0t: track_out is %04h, expected %04h", $time, got, exp);
    end
  endtask

  task automatic check_status(input status_out_t got, input status_out_t exp);
    if (got !== exp) begin
      err_status++;
      $display("MISMATCH at %0t: status_out is %07b, expected %07b", $time, got, exp);
    end
  endtask

  // Status vector carries pointer bit 13 on top
  task automatic check_outputs();
    check_byte("reg_data_out", reg_data_out, m_rdata);
    check_byte("volume_out", volume_out, m_vol);
    check_seek(addr_out, m_seek);
    check_track(track_out, m_track);
    check_status(status_out, {m_ptr[13], m_astart, m_dstart, m_ctrl, m_ack});
  endtask

  ////////////////////
  // Bus operations
  ////////////////////
  task automatic host_access(input logic wr, input reg_sel_t sel, input byte_t wdata,
                             input logic en);
    @(posedge clkin);
    enable      <= en;
    reg_addr    <= sel;
    reg_data_in <= wdata;
    if (wr) begin
      reg_wr_n <= 1'b0;
    end else begin
      reg_rd_n <= 1'b0;
    end
    repeat (3) @(posedge clkin);
    reg_wr_n  <= 1'b1;
    reg_rd_n  <= 1'b1;
    latch_cnt = 0;
    repeat (6) begin
      @(negedge clkin);
      if (volume_latch_out) latch_cnt++;
    end
  endtask

  task automatic host_write(input reg_sel_t sel, input byte_t wdata, input logic en);
    int exp_pulses;
    exp_pulses = 0;
    host_access(1'b1, sel, wdata, en);
    if (en) begin
      case (sel)
        WR_SEEK0: m_seek[7:0] = wdata;
        WR_SEEK1: m_seek[15:8] = wdata;
        WR_SEEK2: m_seek[23:16] = wdata;
        WR_SEEK3: begin
          m_seek[31:24] = wdata;
          m_dstart      = 1'b1;
          m_dbusy       = 1'b1;
        end
        WR_TRACK0: m_track[7:0] = wdata;
        WR_TRACK1: begin
          m_track[15:8] = wdata;
          m_astart      = 1'b1;
          m_abusy       = 1'b1;
        end
        WR_VOLUME: begin
          m_vol      = wdata;
          exp_pulses = 1;
        end
        default: begin
          if (!m_abusy) begin
            m_ctrl = wdata[2:0];
            m_ack  = 1'b1;
          end
        end
      endcase
    end
    check_byte("volume latch pulses", byte_t'(latch_cnt), byte_t'(exp_pulses));
    check_outputs();
  endtask

  task automatic host_read(input reg_sel_t sel, input logic en);
    host_access(1'b0, sel, 8'h00, en);
    if (en) begin
      if (sel == RD_STATUS) begin
        m_rdata = {m_dbusy, m_abusy, m_astat, m_aerr, 3'b001};
      end else if (sel == RD_DATA) begin
        m_rdata = m_buf[m_ptr];
        m_ptr   = m_ptr + 14'd1;
      end else begin
        m_rdata = ID_BYTES[sel - 3'd2];
      end
    end
    check_outputs();
  endtask

  task automatic status_update(input status_bits_t set, input status_bits_t clr);
    @(posedge clkin);
    status_set_bits   <= set;
    status_reset_bits <= clr;
    status_reset_we   <= 1'b1;
    repeat (3) @(posedge clkin);
    status_reset_we <= 1'b0;
    repeat (4) @(negedge clkin);
    // Set first, then clear
    m_abusy = (m_abusy | set[5]) & ~clr[5];
    m_dbusy = (m_dbusy | set[4]) & ~clr[4];
    m_aerr  = (m_aerr | set[3]) & ~clr[3];
    m_astat = (m_astat | set[2:1]) & ~clr[2:1];
    m_ack   = (m_ack | set[0]) & ~clr[0];
    if (clr[5]) m_astart = 1'b0;
    if (clr[4]) m_dstart = 1'b0;
    check_outputs();
  endtask

  task automatic ptr_load(input buf_addr_t a);
    @(posedge clkin);
    msu_address_ext       <= a;
    msu_address_ext_write <= 1'b1;
    repeat (3) @(posedge clkin);
    msu_address_ext_write <= 1'b0;
    repeat (4) @(negedge clkin);
    m_ptr = a;
    check_outputs();
  endtask

  task automatic pgm_write(input buf_addr_t a, input byte_t d);
    @(posedge clkin);
    pgm_address <= a;
    pgm_data    <= d;
    pgm_we_n    <= 1'b0;
    @(posedge clkin);
    pgm_we_n     <= 1'b1;
    m_buf[a]     = d;
    m_written[a] = 1'b1;
  endtask

  // Two buffer windows, one across the wrap and one across bit 13
  function automatic buf_addr_t pick_addr();
    buf_addr_t base;
    base = ($urandom_range(0, 1) == 0) ? 14'h3fe0 : 14'h1fe0;
    return base + buf_addr_t'($urandom_range(0, 63));
  endfunction

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rst_n                 = 1'b0;
    enable                = 1'b1;
    pgm_address           = '0;
    pgm_data              = '0;
    pgm_we_n              = 1'b1;
    reg_addr              = '0;
    reg_data_in           = '0;
    reg_rd_n              = 1'b1;
    reg_wr_n              = 1'b1;
    status_reset_we       = 1'b0;
    status_set_bits       = '0;
    status_reset_bits     = '0;
    msu_address_ext       = '0;
    msu_address_ext_write = 1'b0;
    {m_ptr, m_seek, m_track, m_vol, m_rdata} = '0;
    {m_astart, m_dstart, m_aerr, m_astat, m_ctrl, m_ack} = '0;
    m_abusy = 1'b1;
    m_dbusy = 1'b1;
    void'($urandom(32'hd76c_c407));

    repeat (3) @(posedge clkin);
    rst_n <= 1'b1;
    @(negedge clkin);
    check_outputs();

    for (int i = 0; i < 64; i++) begin
      pgm_write(14'h3fe0 + buf_addr_t'(i), byte_t'($urandom));
      pgm_write(14'h1fe0 + buf_addr_t'(i), byte_t'($urandom));
    end
    ptr_load(14'h3ffc);
    repeat (8) host_read(RD_DATA, 1'b1);
    ptr_load(14'h1ffe);
    repeat (4) host_read(RD_DATA, 1'b1);

    for (int n = 0; n < N_OPS; n++) begin
      op = $urandom_range(0, 9);
      case (op)
        0: pgm_write(pick_addr(), byte_t'($urandom));
        1: ptr_load(pick_addr());
        2, 3: begin
          if (!m_written[m_ptr]) ptr_load(pick_addr());
          host_read(RD_DATA, 1'b1);
        end
        4: host_read(RD_STATUS, 1'b1);
        5: host_read(reg_sel_t'($urandom_range(2, 7)), 1'b1);
        6: host_write(reg_sel_t'($urandom_range(0, 6)), byte_t'($urandom), 1'b1);
        7: host_write(WR_CTRL, byte_t'($urandom), 1'b1);
        8: begin
          status_update(status_bits_t'($urandom), status_bits_t'($urandom));
          host_read(RD_STATUS, 1'b1);
        end
        default: begin
          // Host access with enable low
          if ($urandom_range(0, 1) == 0) begin
            host_read(reg_sel_t'($urandom_range(0, 7)), 1'b0);
          end else begin
            host_write(reg_sel_t'($urandom_range(0, 7)), byte_t'($urandom), 1'b0);
          end
        end
      endcase
    end

    $display("Errors: byte %0d, seek %0d, track %0d, status %0d",
             err_byte, err_seek, err_track, err_status);
    if (err_byte + err_seek + err_track + err_status == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
src/msu_pkg.sv
src/msu_bus_if.sv
src/msu_strobe_sync.sv
src/msu_databuf.sv
src/msu_regs.sv
src/msu_top.sv
dv/msu_props.sv
dv/msu_tb.sv

// File: Makefile
# Verilator build and run of the MSU register window testbench

VERILATOR ?= verilator
TOP       ?= msu_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
PASS_TEXT ?= TESTS PASSED

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
